// File: sim.f
verilog/maria_pkg.sv
verilog/maria_regs.sv
verilog/dma_fetch.sv
verilog/line_ram.sv
verilog/line_playback.sv
verilog/maria.sv
verification/maria_checker.sv
verification/maria_tb.sv

// File: verification/maria_tb.sv
`default_nettype none

module maria_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import maria_pkg::*;

   // Line starts summed over init and the tests below
   // Readback has none and is budgeted as one
   localparam int test_lines      = 1 + 1 + 2 + 8 + 8 + 4 + 3;
   localparam int watchdog_cycles = test_lines * 1200;

   logic        sysclk;
   logic        rst_n;
   logic        reg_we;
   logic [4:0]  reg_addr;
   logic [7:0]  reg_wdata;
   logic [7:0]  reg_rdata;
   logic [15:0] mem_addr;
   logic        mem_rd;
   logic [7:0]  mem_rdata;
   logic        line_start;
   logic        dma_done;
   logic [7:0]  col;
   logic [7:0]  uv_out;

   // External memory behind the DMA bus
   logic [7:0]  mem [65536];

   // Reference model state
   logic [7:0]  mregs [32];
   lram_entry_t mline [2][line_width];
   logic        m_back;

   int          errors;
   int          pass_cnt;
   int          fail_cnt;
   int          done_cnt;
   int          mark;
   int          done_mark;
   int unsigned scratch;

   maria u_maria (.*);

   always #2 sysclk = ~sysclk;

   // Read data one cycle after the strobe
   always @(posedge sysclk) begin
      if (mem_rd) begin
         mem_rdata <= mem[mem_addr];
      end
   end

   // Running count of end-of-list pulses
   always @(posedge sysclk) begin
      if (dma_done) begin
         done_cnt <= done_cnt + 1;
      end
   end

   task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic write_reg(input logic [4:0] a, input logic [7:0] d);
      @(negedge sysclk);
      reg_we    = 1'b1;
      reg_addr  = a;
      reg_wdata = d;
      @(negedge sysclk);
      reg_we = 1'b0;
      // Model keeps only the 28 real registers
      if (a < 5'd28) begin
         mregs[a] = d;
      end
   endtask

   task automatic set_ctrl(input logic kill, input logic dma, input logic border, input logic kang);
      // CK at 7, DMA enable at 6, border at 3, kangaroo at 2
      write_reg(reg_ctrl, {kill, dma, 2'b00, border, kang, 2'b00});
   endtask

   task automatic set_zp(input logic [15:0] zp);
      write_reg(reg_zp_lo, zp[7:0]);
      write_reg(reg_zp_hi, zp[15:8]);
   endtask

   task automatic set_colors();
      for (int i = 0; i < color_map_size; i++) begin
         write_reg(5'(i), 8'($urandom));
      end
   endtask

   // Headers are gfx low, {palette, width}, gfx high, hpos
   task automatic build_list(input logic [15:0] base, input int n_obj, input int hmax);
      logic [15:0] a;
      logic [15:0] gfx;
      a = base;
      for (int i = 0; i < n_obj; i++) begin
         // Graphics kept in the upper half away from the lists
         gfx          = 16'h8000 + 16'($urandom % 32'h7000);
         mem[a]       = gfx[7:0];
         mem[a + 1]   = {3'($urandom % 8), 5'(1 + $urandom % 31)};
         mem[a + 2]   = gfx[15:8];
         mem[a + 3]   = 8'($urandom % hmax);
         a            = a + 16'd4;
      end
      // Zero width closes the list
      mem[a]     = 8'($urandom);
      mem[a + 1] = {3'($urandom % 8), 5'd0};
   endtask

   // Model of one full list fetch into the back line
   task automatic model_render();
      logic [15:0] a;
      logic [15:0] gfx;
      logic [7:0]  b1;
      logic [7:0]  gbyte;
      logic [1:0]  v;
      int          c;
      a = {mregs[reg_zp_hi], mregs[reg_zp_lo]};
      while (mem[a + 16'd1][4:0] != 5'd0) begin
         b1  = mem[a + 16'd1];
         gfx = {mem[a + 16'd2], mem[a]};
         for (int j = 0; j < int'(b1[4:0]); j++) begin
            gbyte = mem[gfx + 16'(j)];
            for (int k = 0; k < 4; k++) begin
               c = int'(mem[a + 16'd3]) + 4 * j + k;
               // Most significant pair first
               v = gbyte[7 - 2 * k -: 2];
               if (c < line_width && (v != 2'd0 || mregs[reg_ctrl][ctrl_kangaroo])) begin
                  mline[m_back][8'(c)] = {b1[7:5], v};
               end
            end
         end
         a = a + 16'd4;
      end
   endtask

   task automatic pulse_line(input bit render);
      @(negedge sysclk);
      line_start = 1'b1;
      @(negedge sysclk);
      line_start = 1'b0;
      // Halves swap on the pulse
      m_back = ~m_back;
      if (render && mregs[reg_ctrl][ctrl_dma_en]) begin
         model_render();
      end
   endtask

   task automatic wait_done(input int mark_cnt);
      int n;
      n = 0;
      while (done_cnt == mark_cnt && n < 3000) begin
         @(negedge sysclk);
         n++;
      end
      if (done_cnt == mark_cnt) begin
         $display("error at %0d ns: dma_done never arrived for the list", $time);
         errors++;
      end
   endtask

   function automatic logic [7:0] expected_color(input int c);
      lram_entry_t e;
      logic [7:0]  res;
      if (c >= line_width) begin
         res = mregs[reg_ctrl][ctrl_border] ? 8'h00 : mregs[0];
      end else begin
         e = mline[~m_back][8'(c)];
         // Pixel zero is background and otherwise entry 1 + 3p + v - 1
         if (e.pixel == 2'd0) begin
            res = mregs[0];
         end else begin
            res = mregs[5'(1 + 3 * e.palette + e.pixel - 1)];
         end
      end
      if (mregs[reg_ctrl][ctrl_color_kill]) begin
         res[7:4] = 4'h0;
      end
      return res;
   endfunction

   // Sweep of columns 0..169 with the output two cycles behind
   // Front entries are cleared as they are read
   task automatic sweep(input bit check);
      int c;
      for (int i = 0; i < 172; i++) begin
         @(negedge sysclk);
         if (i >= 2) begin
            c = i - 2;
            if (check) begin
               check_value($sformatf("uv_out col %0d", c), 16'(uv_out), 16'(expected_color(c)));
            end
            if (c < line_width) begin
               mline[~m_back][8'(c)] = '0;
            end
         end
         col = (i < 170) ? 8'(i) : 8'd200;
      end
   endtask

   task automatic run_line(input int n_obj, input int hmax, input logic kill,
                           input logic border, input logic kang);
      int mark_cnt;
      build_list(16'h0100, n_obj, hmax);
      set_zp(16'h0100);
      set_ctrl(kill, 1'b1, border, kang);
      mark_cnt = done_cnt;
      pulse_line(1'b1);
      wait_done(mark_cnt);
      // Swap with DMA off so the rendered line stays put
      set_ctrl(kill, 1'b0, border, kang);
      pulse_line(1'b1);
      sweep(1'b1);
   endtask

   task automatic end_test(input string name, input int mark_err);
      if (errors == mark_err) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d errors", name, errors - mark_err);
      end
   endtask

   initial begin
      repeat (watchdog_cycles) @(posedge sysclk);
      $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
      $display("Regression failed");
      $finish;
   end

   initial begin
      scratch    = $urandom(45);
      sysclk     = 1'b0;
      rst_n      = 1'b0;
      reg_we     = 1'b0;
      reg_addr   = 5'd0;
      reg_wdata  = 8'h00;
      line_start = 1'b0;
      mem_rdata  = 8'h00;
      // Idle column sits in the border so nothing is cleared
      col        = 8'd200;
      m_back     = 1'b0;
      errors     = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      done_cnt   = 0;
      for (int i = 0; i < 65536; i++) begin
         mem[i] = 8'($urandom);
      end
      for (int i = 0; i < 32; i++) begin
         mregs[i] = 8'h00;
      end
      for (int i = 0; i < line_width; i++) begin
         mline[0][i] = '0;
         mline[1][i] = '0;
      end
      repeat (4) @(posedge sysclk);
      @(negedge sysclk);
      rst_n = 1'b1;
      pulse_line(1'b0);

      // Register readback
      mark = errors;
      for (int a = 0; a < 32; a++) begin
         write_reg(5'(a), 8'($urandom));
      end
      repeat (40) write_reg(5'($urandom % 32), 8'($urandom));
      for (int a = 0; a < 32; a++) begin
         @(negedge sysclk);
         reg_addr = 5'(a);
         @(negedge sysclk);
         check_value("reg_rdata", 16'(reg_rdata), (a < 28) ? 16'(mregs[a]) : 16'h0000);
      end
      end_test("register readback", mark);

      mark = errors;
      set_colors();
      run_line(1, 200, 1'b0, 1'b0, 1'b0);
      end_test("single object", mark);

      mark = errors;
      for (int kang = 0; kang < 2; kang++) begin
         repeat (2) run_line(3 + int'($urandom % 3), 120, 1'b0, 1'b0, 1'(kang));
      end
      end_test("transparency and overlap", mark);

      // All four kill and border pairs
      mark = errors;
      for (int m = 0; m < 4; m++) begin
         set_colors();
         run_line(2, 200, 1'(m >> 1), 1'(m), 1'($urandom % 2));
      end
      end_test("kill, border and background", mark);

      mark = errors;
      run_line(3, 160, 1'b0, 1'b0, 1'b0);
      done_mark = done_cnt;
      repeat (2) begin
         pulse_line(1'b1);
         sweep(1'b1);
      end
      check_value("dma_done count", 16'(done_cnt), 16'(done_mark));
      end_test("clear on read and DMA off", mark);

      mark = errors;
      // Ten objects take well over the 60 cycles before the kill
      build_list(16'h0100, 10, 160);
      build_list(16'h0400, 3, 140);
      set_zp(16'h0100);
      set_ctrl(1'b0, 1'b1, 1'b0, 1'b1);
      done_mark = done_cnt;
      pulse_line(1'b0);
      repeat (60) @(negedge sysclk);
      set_zp(16'h0400);
      check_value("dma_done count", 16'(done_cnt), 16'(done_mark));
      pulse_line(1'b1);
      // Partial line from the killed fetch is flushed unchecked
      sweep(1'b0);
      wait_done(done_mark);
      check_value("dma_done count", 16'(done_cnt), 16'(done_mark + 1));
      set_ctrl(1'b0, 1'b0, 1'b0, 1'b1);
      pulse_line(1'b1);
      sweep(1'b1);
      end_test("kill on early line start", mark);

      if (u_maria.u_checker.assert_fails != 0) begin
         $display("bus timing assertions failed %0d times", u_maria.u_checker.assert_fails);
         fail_cnt++;
      end
      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/maria_checker.sv
`default_nettype none

module maria_checker (
   input logic       sysclk,
   input logic       rst_n,
   input logic       mem_rd,
   input logic       dma_done,
   input logic       line_start,
   input logic [7:0] uv_out
);
   timeunit 1ns;
   timeprecision 100ps;

   logic seen_line;
   int   assert_fails = 0;

   // Set by the first line start after reset
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         seen_line <= 1'b0;
      end else if (line_start) begin
         seen_line <= 1'b1;
      end
   end

   // Every read is followed by its data cycle
   a_rd_gap: assert property (@(posedge sysclk) disable iff (!rst_n) mem_rd |=> !mem_rd)
      else begin
         $error("mem_rd high on two cycles in a row");
         assert_fails++;
      end

   a_done_pulse: assert property (@(posedge sysclk) disable iff (!rst_n) dma_done |=> !dma_done)
      else begin
         $error("dma_done longer than one cycle");
         assert_fails++;
      end

   // Registers all zero before the first line, so output is black
   a_uv_quiet: assert property (@(posedge sysclk) disable iff (!rst_n)
      !seen_line |-> uv_out == 8'h00)
      else begin
         $error("uv_out nonzero before the first line start");
         assert_fails++;
      end

endmodule

bind maria maria_checker u_checker (.*);

`default_nettype wire

// File: verilog/maria.sv
`default_nettype none

module maria (
   input  logic        sysclk,
   input  logic        rst_n,
   // CPU register port
   input  logic        reg_we,
   input  logic [4:0]  reg_addr,
   input  logic [7:0]  reg_wdata,
   output logic [7:0]  reg_rdata,
   // DMA memory bus
   output logic [15:0] mem_addr,
   output logic        mem_rd,
   input  logic [7:0]  mem_rdata,
   // Line timing
   input  logic        line_start,
   output logic        dma_done,
   // Pixel output
   input  logic [7:0]  col,
   output logic [7:0]  uv_out
);
   import maria_pkg::*;

   maria_cfg_t  cfg;
   lram_write_t lram_wr;
   lram_entry_t rd_entry;
   logic [7:0]  rd_col;

   // Register file
   maria_regs u_regs (
      .sysclk    (sysclk),
      .rst_n     (rst_n),
      .reg_we    (reg_we),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .cfg       (cfg)
   );

   // Display list DMA, the producer
   dma_fetch u_fetch (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .line_start (line_start),
      .cfg        (cfg),
      .mem_addr   (mem_addr),
      .mem_rd     (mem_rd),
      .mem_rdata  (mem_rdata),
      .lram_wr    (lram_wr),
      .dma_done   (dma_done)
   );

   // Double-buffered line
   line_ram u_lram (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .line_start (line_start),
      .kangaroo   (cfg.kangaroo),
      .lram_wr    (lram_wr),
      .rd_col     (rd_col),
      .rd_entry   (rd_entry)
   );

   // Color lookup, the consumer
   line_playback u_play (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .col      (col),
      .rd_col   (rd_col),
      .rd_entry (rd_entry),
      .cfg      (cfg),
      .uv_out   (uv_out)
   );

endmodule

`default_nettype wire

// File: verilog/line_playback.sv
`default_nettype none

module line_playback (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  logic [7:0]             col,
   output logic [7:0]             rd_col,
   input  maria_pkg::lram_entry_t rd_entry,
   input  maria_pkg::maria_cfg_t  cfg,
   output logic [7:0]             uv_out
);
   import maria_pkg::*;

   logic       in_range_q;
   logic [4:0] cm_idx;
   logic [7:0] bg_color;
   logic [7:0] color;

   // Column goes straight to the line RAM
   assign rd_col = col;

   // In-range flag lines up with the registered RAM read
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         in_range_q <= 1'b0;
      end else begin
         in_range_q <= col < line_width;
      end
   end

   // Palette p, pixel v maps to entry 1 + 3p + v - 1
   assign cm_idx   = ({2'b00, rd_entry.palette} * 5'd3) + {3'b000, rd_entry.pixel};
   assign bg_color = cfg.color_map[0];

   always_comb begin
      if (!in_range_q) begin
         // Border area, black or background
         color = cfg.border ? 8'h00 : bg_color;
      end else if (rd_entry.pixel == 2'd0) begin
         color = bg_color;
      end else begin
         color = cfg.color_map[cm_idx];
      end
   end

   // Second stage, kill drops the chroma nibble
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         uv_out <= 8'h00;
      end else begin
         uv_out <= cfg.color_kill ? {4'h0, color[3:0]} : color;
      end
   end

endmodule

`default_nettype wire

// File: verilog/line_ram.sv
`default_nettype none

module line_ram (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  logic                   line_start,
   input  logic                   kangaroo,
   input  maria_pkg::lram_write_t lram_wr,
   input  logic [7:0]             rd_col,
   output maria_pkg::lram_entry_t rd_entry
);
   import maria_pkg::*;

   // Two line halves, back is written while front plays
   lram_entry_t bank [2][line_width];
   // Index of the back bank, front is the other one
   logic        back_sel;
   logic        front_sel;
   logic        wr_ok;
   logic        rd_ok;

   assign front_sel = ~back_sel;

   // Zero pixel is transparent unless kangaroo mode
   assign wr_ok = lram_wr.we && (lram_wr.col < line_width) &&
                  ((lram_wr.entry.pixel != 2'd0) || kangaroo);

   // Border columns do not touch the banks
   assign rd_ok = rd_col < line_width;

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         back_sel <= 1'b0;
         rd_entry <= '0;
         for (int i = 0; i < line_width; i++) begin
            bank[0][i] <= '0;
            bank[1][i] <= '0;
         end
      end else begin
         // Swap halves at each line
         if (line_start) begin
            back_sel <= ~back_sel;
         end

         // Later writes overwrite earlier ones
         if (wr_ok) begin
            bank[back_sel][lram_wr.col] <= lram_wr.entry;
         end

         // Read and clear front entry in the same cycle
         if (rd_ok) begin
            rd_entry                  <= bank[front_sel][rd_col];
            bank[front_sel][rd_col]   <= '0;
         end else begin
            rd_entry <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/dma_fetch.sv
`default_nettype none

module dma_fetch (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  logic                   line_start,
   input  maria_pkg::maria_cfg_t  cfg,
   output logic [15:0]            mem_addr,
   output logic                   mem_rd,
   input  logic [7:0]             mem_rdata,
   output maria_pkg::lram_write_t lram_wr,
   output logic                   dma_done
);
   import maria_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_START,
      S_HDR_RD,
      S_HDR_DATA,
      S_GFX_RD,
      S_GFX_DATA,
      S_PIX
   } state_t;

   state_t      state;
   logic [15:0] list_addr;
   logic [15:0] gfx_addr;
   logic [1:0]  hdr_idx;
   logic [2:0]  palette_q;
   logic [4:0]  width_q;
   // Nine bits so hpos + 4j + k never wraps into the visible range
   logic [8:0]  col_q;
   logic [7:0]  shift_q;
   logic [1:0]  pix_cnt;
   logic        list_end;

   // Header byte 1 is {palette[2:0], width[4:0]}, zero width closes the list
   assign list_end = (state == S_HDR_DATA) && (hdr_idx == 2'd1) && (mem_rdata[4:0] == 5'd0);

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= S_IDLE;
         list_addr <= 16'h0000;
         gfx_addr  <= 16'h0000;
         hdr_idx   <= 2'd0;
         palette_q <= 3'd0;
         width_q   <= 5'd0;
         col_q     <= 9'd0;
         shift_q   <= 8'h00;
         pix_cnt   <= 2'd0;
         dma_done  <= 1'b0;
      end else begin
         dma_done <= list_end && !line_start;
         if (line_start) begin
            // New line, any fetch in flight is dropped without dma_done
            list_addr <= cfg.zp;
            hdr_idx   <= 2'd0;
            state     <= cfg.dma_en ? S_START : S_IDLE;
         end else begin
            case (state)
               // Spacer so a killed read is never followed by another at once
               S_START:    state <= S_HDR_RD;
               S_HDR_RD:   state <= S_HDR_DATA;
               S_HDR_DATA: begin
                  list_addr <= list_addr + 16'd1;
                  hdr_idx   <= hdr_idx + 2'd1;
                  state     <= S_HDR_RD;
                  case (hdr_idx)
                     2'd0: gfx_addr[7:0] <= mem_rdata;
                     2'd1: begin
                        palette_q <= mem_rdata[7:5];
                        width_q   <= mem_rdata[4:0];
                        if (list_end) begin
                           state <= S_IDLE;
                        end
                     end
                     2'd2: gfx_addr[15:8] <= mem_rdata;
                     default: begin
                        // Horizontal position, then graphics bytes follow
                        col_q <= {1'b0, mem_rdata};
                        state <= S_GFX_RD;
                     end
                  endcase
               end
               S_GFX_RD:   state <= S_GFX_DATA;
               S_GFX_DATA: begin
                  shift_q  <= mem_rdata;
                  gfx_addr <= gfx_addr + 16'd1;
                  width_q  <= width_q - 5'd1;
                  pix_cnt  <= 2'd0;
                  state    <= S_PIX;
               end
               S_PIX: begin
                  // MSB pair first, one pixel per cycle
                  shift_q <= {shift_q[5:0], 2'b00};
                  col_q   <= col_q + 9'd1;
                  pix_cnt <= pix_cnt + 2'd1;
                  if (pix_cnt == 2'd3) begin
                     state <= (width_q == 5'd0) ? S_HDR_RD : S_GFX_RD;
                  end
               end
               default:    state <= S_IDLE;
            endcase
         end
      end
   end

   // Bus outputs decoded from state
   assign mem_rd   = (state == S_HDR_RD) || (state == S_GFX_RD);
   assign mem_addr = (state == S_GFX_RD) ? gfx_addr : list_addr;

   // Off-line columns dropped, no write in the line_start cycle
   assign lram_wr.we            = (state == S_PIX) && (col_q < line_width) && !line_start;
   assign lram_wr.col           = col_q[7:0];
   assign lram_wr.entry.palette = palette_q;
   assign lram_wr.entry.pixel   = shift_q[7:6];

endmodule

`default_nettype wire

// File: verilog/maria_regs.sv
`default_nettype none

module maria_regs (
   input  logic                  sysclk,
   input  logic                  rst_n,
   input  logic                  reg_we,
   input  logic [4:0]            reg_addr,
   input  logic [7:0]            reg_wdata,
   output logic [7:0]            reg_rdata,
   output maria_pkg::maria_cfg_t cfg
);
   import maria_pkg::*;

   logic [color_map_size-1:0][7:0] color_map;
   logic [7:0]                     ctrl;
   logic [7:0]                     zp_lo;
   logic [7:0]                     zp_hi;
   logic [7:0]                     rd_mux;

   // CPU writes land on the edge where reg_we is high
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         color_map <= '0;
         ctrl      <= 8'h00;
         zp_lo     <= 8'h00;
         zp_hi     <= 8'h00;
      end else if (reg_we) begin
         if (reg_addr < color_map_size) begin
            color_map[reg_addr] <= reg_wdata;
         end else if (reg_addr == reg_ctrl) begin
            ctrl <= reg_wdata;
         end else if (reg_addr == reg_zp_lo) begin
            zp_lo <= reg_wdata;
         end else if (reg_addr == reg_zp_hi) begin
            zp_hi <= reg_wdata;
         end
      end
   end

   // Readback select, addresses 28..31 give zero
   always_comb begin
      rd_mux = 8'h00;
      if (reg_addr < color_map_size) begin
         rd_mux = color_map[reg_addr];
      end else if (reg_addr == reg_ctrl) begin
         rd_mux = ctrl;
      end else if (reg_addr == reg_zp_lo) begin
         rd_mux = zp_lo;
      end else if (reg_addr == reg_zp_hi) begin
         rd_mux = zp_hi;
      end
   end

   // Registered readback, one cycle after the address
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         reg_rdata <= 8'h00;
      end else begin
         reg_rdata <= rd_mux;
      end
   end

   // Unpack control bits for the other blocks
   assign cfg.color_map  = color_map;
   assign cfg.color_kill = ctrl[ctrl_color_kill];
   assign cfg.border     = ctrl[ctrl_border];
   assign cfg.kangaroo   = ctrl[ctrl_kangaroo];
   assign cfg.dma_en     = ctrl[ctrl_dma_en];
   assign cfg.zp         = {zp_hi, zp_lo};

endmodule

`default_nettype wire

// File: verilog/maria_pkg.sv
`default_nettype none

package maria_pkg;

   // Line memory and color map sizes
   localparam int line_width     = 160;
   localparam int color_map_size = 25;

   // Register file indices
   // 0 is background, 1..24 are eight palettes of three colors
   localparam logic [4:0] reg_ctrl  = 5'd25;
   localparam logic [4:0] reg_zp_lo = 5'd26;
   localparam logic [4:0] reg_zp_hi = 5'd27;

   // Control byte layout
   // {CK, DM1, DM0, CW, BC, KM, RM1, RM0}, only CK, DM1, BC and KM kept
   localparam int ctrl_color_kill = 7;
   localparam int ctrl_dma_en     = 6;
   localparam int ctrl_border     = 3;
   localparam int ctrl_kangaroo   = 2;

   // One cell of the line memory
   typedef struct packed {
      logic [2:0] palette;
      logic [1:0] pixel;
   } lram_entry_t;

   // One pixel write from the fetcher
   typedef struct packed {
      logic        we;
      logic [7:0]  col;
      lram_entry_t entry;
   } lram_write_t;

   // Decoded register state, shared by every block
   typedef struct packed {
      logic [color_map_size-1:0][7:0] color_map;
      logic                           color_kill;
      logic                           border;
      logic                           kangaroo;
      logic                           dma_en;
      logic [15:0]                    zp;
   } maria_cfg_t;

endpackage

`default_nettype wire
